// File: include/cpu4_defines.svh
`ifndef CPU4_DEFINES_SVH
`define CPU4_DEFINES_SVH

// Instruction word from the program ROM
`define CPU4_IW 12

// Data nibble
`define CPU4_DW 4

// Shared by ROM and RAM, also the X and Y width
`define CPU4_AW 12

`define CPU4_RESET_PC 12'h100

// Fixed instruction length in clocks
`define CPU4_CYCLES 7

`endif

// File: hdl/isa_pkg.sv
package isa_pkg;

    // Decoded operations, anything unknown folds into OP_NOP
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_CP_XH = 4'd1,
        OP_CP_XL = 4'd2,
        OP_CP_YH = 4'd3,
        OP_CP_YL = 4'd4,
        OP_CP_RI = 4'd5,
        OP_CP_RQ = 4'd6,
        OP_LD_RI = 4'd7,
        OP_LD_RQ = 4'd8,
        OP_LD_X  = 4'd9,
        OP_LD_Y  = 4'd10
    } op_e;

    // r and q operand fields
    typedef enum logic [1:0] {
        R_A  = 2'd0,
        R_B  = 2'd1,
        R_MX = 2'd2,  // RAM at X
        R_MY = 2'd3   // RAM at Y
    } rsel_e;

endpackage

// File: hdl/core_pkg.sv
package core_pkg;

    // One state per clock of the instruction
    typedef enum logic [2:0] {
        MC_FETCH   = 3'd0,
        MC_DECODE  = 3'd1,
        MC_MEMRD   = 3'd2,
        MC_MEMWAIT = 3'd3,
        MC_EXEC    = 3'd4,
        MC_WRITE   = 3'd5,
        MC_RETIRE  = 3'd6
    } mc_state_e;

    typedef enum logic [2:0] {
        WB_NONE = 3'd0,
        WB_A    = 3'd1,
        WB_B    = 3'd2,
        WB_MEM  = 3'd3,
        WB_X    = 3'd4,
        WB_Y    = 3'd5
    } wb_target_e;

endpackage

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns
`include "cpu4_defines.svh"

module instr_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mc_state_e           state,
    input  logic [`CPU4_IW-1:0] rom_data,
    output op_e                 op,
    output rsel_e               r_sel,
    output rsel_e               q_sel,
    output logic [7:0]          imm,
    output wb_target_e          wb
);

    logic [`CPU4_IW-1:0] ir;

    // LD destination r to write-back target
    function automatic wb_target_e wb_of(input logic [1:0] r);
        wb_target_e t;
        case (r)
            2'd0:    t = WB_A;
            2'd1:    t = WB_B;
            default: t = WB_MEM;
        endcase
        return t;
    endfunction

    // ROM answers the MC_FETCH address during MC_DECODE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= 12'hFFB;  // NOP
        end else if (state == MC_DECODE) begin
            ir <= rom_data;
        end
    end

    // Every immediate sits at the bottom of the word
    assign imm = ir[7:0];

    always_comb begin
        op    = OP_NOP;
        r_sel = R_A;
        q_sel = R_A;
        wb    = WB_NONE;
        casez (ir)
            12'hA4?: op = OP_CP_XH;
            12'hA5?: op = OP_CP_XL;
            12'hA6?: op = OP_CP_YH;
            12'hA7?: op = OP_CP_YL;
            12'b1101_11??_????: begin  // DC0..DFF
                op    = OP_CP_RI;
                r_sel = rsel_e'(ir[5:4]);
            end
            12'hF0?: begin
                op    = OP_CP_RQ;
                r_sel = rsel_e'(ir[3:2]);
                q_sel = rsel_e'(ir[1:0]);
            end
            12'b1110_00??_????: begin  // E00..E3F
                op    = OP_LD_RI;
                r_sel = rsel_e'(ir[5:4]);
                wb    = wb_of(ir[5:4]);
            end
            12'hEC?: begin
                op    = OP_LD_RQ;
                r_sel = rsel_e'(ir[3:2]);
                q_sel = rsel_e'(ir[1:0]);
                wb    = wb_of(ir[3:2]);
            end
            12'hB??: begin
                op = OP_LD_X;
                wb = WB_X;
            end
            12'h8??: begin
                op = OP_LD_Y;
                wb = WB_Y;
            end
            default: ;  // NOP and unsupported words
        endcase
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`include "cpu4_defines.svh"

module reg_file
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mc_state_e           state,
    input  op_e                 op,
    input  rsel_e               r_sel,
    input  rsel_e               q_sel,
    input  logic [7:0]          imm,
    input  wb_target_e          wb,
    input  logic [`CPU4_DW-1:0] ram_rdata,
    output logic [`CPU4_DW-1:0] opnd_a,
    output logic [`CPU4_DW-1:0] opnd_b,
    output logic [`CPU4_AW-1:0] ram_addr,
    output logic [`CPU4_DW-1:0] ram_wdata
);

    logic [`CPU4_DW-1:0] a_reg;
    logic [`CPU4_DW-1:0] b_reg;
    logic [`CPU4_AW-1:0] x_reg;
    logic [`CPU4_AW-1:0] y_reg;
    logic [`CPU4_DW-1:0] mem_lat;  // First RAM operand
    logic                r_reads;
    logic                two_reads;
    rsel_e               first_sel;
    logic [`CPU4_AW-1:0] first_addr;
    logic [`CPU4_AW-1:0] q_addr;
    logic [`CPU4_AW-1:0] r_addr;
    logic [`CPU4_DW-1:0] r_val;
    logic [`CPU4_DW-1:0] q_val;
    logic [`CPU4_DW-1:0] wb_val;

    assign r_reads = (op == OP_CP_RI) || (op == OP_CP_RQ);

    // MX against MY needs a second RAM read, issued in MC_MEMWAIT
    assign two_reads = (op == OP_CP_RQ) && r_sel[1] && q_sel[1] && (r_sel != q_sel);

    assign first_sel  = (r_reads && r_sel[1]) ? r_sel : q_sel;
    assign first_addr = (first_sel == R_MY) ? y_reg : x_reg;
    assign q_addr     = (q_sel == R_MY) ? y_reg : x_reg;
    assign r_addr     = (r_sel == R_MY) ? y_reg : x_reg;

    always_comb begin
        if (state == MC_WRITE) begin
            ram_addr = r_addr;
        end else if (state == MC_MEMWAIT && two_reads) begin
            ram_addr = q_addr;
        end else begin
            ram_addr = first_addr;
        end
    end

    // Data for the MC_MEMRD address
    always_ff @(posedge clk) begin
        if (state == MC_MEMWAIT) begin
            mem_lat <= ram_rdata;
        end
    end

    always_comb begin
        case (r_sel)
            R_A:     r_val = a_reg;
            R_B:     r_val = b_reg;
            default: r_val = mem_lat;
        endcase
        case (q_sel)
            R_A:     q_val = a_reg;
            R_B:     q_val = b_reg;
            default: q_val = two_reads ? ram_rdata : mem_lat;  // Second read lands in MC_EXEC
        endcase
    end

    always_comb begin
        case (op)
            OP_CP_XH: opnd_a = x_reg[11:8];
            OP_CP_XL: opnd_a = x_reg[3:0];
            OP_CP_YH: opnd_a = y_reg[11:8];
            OP_CP_YL: opnd_a = y_reg[3:0];
            OP_CP_RI,
            OP_CP_RQ: opnd_a = r_val;
            default:  opnd_a = '0;
        endcase
        case (op)
            OP_CP_XH, OP_CP_XL, OP_CP_YH, OP_CP_YL,
            OP_CP_RI: opnd_b = imm[3:0];
            OP_CP_RQ: opnd_b = q_val;
            default:  opnd_b = '0;
        endcase
    end

    assign wb_val    = (op == OP_LD_RQ) ? q_val : imm[3:0];
    assign ram_wdata = wb_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_reg <= '0;
            b_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
        end else if (state == MC_WRITE) begin
            case (wb)
                WB_A:    a_reg <= wb_val;
                WB_B:    b_reg <= wb_val;
                WB_X:    x_reg <= {4'h0, imm};  // Upper nibble cleared
                WB_Y:    y_reg <= {4'h0, imm};
                default: ;  // Memory writes go out on the RAM port
            endcase
        end
    end

endmodule

// File: hdl/compare_unit.sv
`timescale 1ns/1ns
`include "cpu4_defines.svh"

module compare_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mc_state_e           state,
    input  op_e                 op,
    input  logic [`CPU4_DW-1:0] opnd_a,
    input  logic [`CPU4_DW-1:0] opnd_b,
    output logic                carry,
    output logic                zero
);

    logic is_cp;
    logic lt;
    logic eq;

    assign is_cp = op inside {OP_CP_XH, OP_CP_XL, OP_CP_YH, OP_CP_YL, OP_CP_RI, OP_CP_RQ};

    // Unsigned nibbles
    assign lt = opnd_a < opnd_b;
    assign eq = opnd_a == opnd_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (state == MC_EXEC && is_cp) begin
            carry <= lt;  // Borrow out of a - b
            zero  <= eq;
        end
    end

endmodule

// File: hdl/cycle_sequencer.sv
`timescale 1ns/1ns
`include "cpu4_defines.svh"

module cycle_sequencer
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    output mc_state_e           state,
    output logic [`CPU4_AW-1:0] pc,
    output logic                instr_done,
    input  wb_target_e          wb,
    output logic                ram_we
);

    localparam mc_state_e LAST_STATE = mc_state_e'(`CPU4_CYCLES - 1);

    // Fixed ring, no stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MC_FETCH;
            pc    <= `CPU4_RESET_PC;
        end else if (state == LAST_STATE) begin
            state <= MC_FETCH;
            pc    <= pc + 1'b1;
        end else begin
            state <= mc_state_e'(state + 1'b1);
        end
    end

    assign instr_done = (state == LAST_STATE);

    // One write strobe per LD to MX or MY
    assign ram_we = (state == MC_WRITE) && (wb == WB_MEM);

endmodule

// File: hdl/cpu4_core.sv
`timescale 1ns/1ns
`include "cpu4_defines.svh"

module cpu4_core
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    output logic [`CPU4_AW-1:0] rom_addr,
    input  logic [`CPU4_IW-1:0] rom_data,
    output logic [`CPU4_AW-1:0] ram_addr,
    input  logic [`CPU4_DW-1:0] ram_rdata,
    output logic [`CPU4_DW-1:0] ram_wdata,
    output logic                ram_we,
    output logic                carry,
    output logic                zero,
    output logic                instr_done
);

    mc_state_e           state;
    op_e                 op;
    rsel_e               r_sel;
    rsel_e               q_sel;
    logic [7:0]          imm;
    wb_target_e          wb;
    logic [`CPU4_DW-1:0] opnd_a;
    logic [`CPU4_DW-1:0] opnd_b;

    cycle_sequencer cycle_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .pc         (rom_addr),  // Fetch address is the PC
        .instr_done (instr_done),
        .wb         (wb),
        .ram_we     (ram_we)
    );

    instr_decoder instr_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .rom_data (rom_data),
        .op       (op),
        .r_sel    (r_sel),
        .q_sel    (q_sel),
        .imm      (imm),
        .wb       (wb)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .op        (op),
        .r_sel     (r_sel),
        .q_sel     (q_sel),
        .imm       (imm),
        .wb        (wb),
        .ram_rdata (ram_rdata),
        .opnd_a    (opnd_a),
        .opnd_b    (opnd_b),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    compare_unit compare_unit_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .op     (op),
        .opnd_a (opnd_a),
        .opnd_b (opnd_b),
        .carry  (carry),
        .zero   (zero)
    );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: verification/cpu4_tb.sv
`timescale 1ns/1ns

module cpu4_tb;

    localparam int MAX_CASES    = 128;
    localparam int RANDOM_CASES = 40;
    localparam int INSTR_CLOCKS = 7;
    localparam int TIMEOUT      = 20;

    logic        clk;
    logic        rst_n;
    logic [11:0] rom_addr;
    logic [11:0] rom_data;
    logic [11:0] ram_addr;
    logic [3:0]  ram_rdata;
    logic [3:0]  ram_wdata;
    logic        ram_we;
    logic        carry;
    logic        zero;
    logic        instr_done;

    logic [11:0] rom [0:4095];
    logic [3:0]  ram [0:4095];
    logic [39:0] cases [0:MAX_CASES-1];  // Word, mask, carry, zero, write address, write data
    logic [11:0] fetch_addr;
    logic [11:0] read_addr;
    logic [11:0] last_waddr;
    logic [3:0]  last_wdata;
    logic        timed_out;
    int          n_cases;
    int          n_writes;
    int          errors;
    int          clocks;
    int          k;

    tb_clock #(.PERIOD(40)) tb_clock_inst (.clk(clk));

    cpu4_core cpu4_core_inst (.*);

    // Addresses sampled mid-cycle, writes applied here too
    always @(negedge clk) begin
        fetch_addr = rom_addr;
        read_addr  = ram_addr;
        if (ram_we === 1'b1) begin
            ram[ram_addr] = ram_wdata;
            last_waddr    = ram_addr;
            last_wdata    = ram_wdata;
            n_writes++;
        end
    end

    always @(posedge clk) begin
        #1;
        rom_data  = rom[fetch_addr];
        ram_rdata = ram[read_addr];
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_value(input string name, input logic [11:0] exp_v,
                                input logic [11:0] act_v);
        errors++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    endtask

    // A and B are loaded first so both are known before any compare
    task automatic add_random_cases();
        logic [31:0] seed;
        logic [11:0] word;
        logic [3:0]  a_val;
        logic [3:0]  b_val;
        logic        c_flag;
        logic        z_flag;
        int          kind;
        seed   = 32'h8c11_ed33;
        a_val  = 4'h0;
        b_val  = 4'h0;
        c_flag = (n_cases > 0) ? cases[n_cases-1][20] : 1'b0;
        z_flag = (n_cases > 0) ? cases[n_cases-1][16] : 1'b0;
        for (int i = 0; i < RANDOM_CASES && n_cases < MAX_CASES; i++) begin
            seed = lcg_next(seed);
            kind = (i < 2) ? i : int'(seed[25:24]) % 3;
            case (kind)
                0: begin
                    word  = {8'hE0, seed[19:16]};  // LD A,i
                    a_val = seed[19:16];
                end
                1: begin
                    word  = {8'hE1, seed[19:16]};  // LD B,i
                    b_val = seed[19:16];
                end
                default: begin
                    word   = {8'hF0, 1'b0, seed[12], 1'b0, seed[8]};
                    c_flag = (seed[12] ? b_val : a_val) < (seed[8] ? b_val : a_val);
                    z_flag = (seed[12] ? b_val : a_val) == (seed[8] ? b_val : a_val);
                end
            endcase
            cases[n_cases] = {word, 4'h3, 3'b0, c_flag, 3'b0, z_flag, 12'hFFF, 4'h0};
            n_cases++;
        end
    endtask

    task automatic check_case(input int idx);
        logic [39:0] entry;
        entry = cases[idx];
        if (rom_addr !== 12'h100 + idx) report_value("rom_addr", 12'h100 + idx, rom_addr);
        if (clocks != INSTR_CLOCKS) report_value("instr_done spacing", INSTR_CLOCKS, clocks);
        if (entry[24]) begin
            if (carry !== entry[20]) report_value("carry", entry[20], carry);
            if (zero !== entry[16]) report_value("zero", entry[16], zero);
        end
        if (entry[25] && entry[15:4] == 12'hFFF) begin
            if (n_writes != 0) report_value("ram_we pulses", 0, n_writes);
        end
        if (entry[25] && entry[15:4] != 12'hFFF) begin
            if (n_writes != 1) report_value("ram_we pulses", 1, n_writes);
            if (last_waddr !== entry[15:4]) report_value("ram_addr", entry[15:4], last_waddr);
            if (last_wdata !== entry[3:0]) report_value("ram_wdata", entry[3:0], last_wdata);
        end
        n_writes = 0;
    endtask

    initial begin
        rst_n      = 1'b0;
        rom_data   = 12'hFFB;
        ram_rdata  = 4'h0;
        fetch_addr = 12'h000;
        read_addr  = 12'h000;
        n_writes   = 0;
        errors     = 0;
        timed_out  = 1'b0;
        for (int a = 0; a < 4096; a++) begin
            rom[a] = 12'hFFB;  // NOP past the program
            ram[a] = a[11:8] ^ a[7:4] ^ a[3:0] ^ 4'h5;
        end
        $readmemh("verification/cp_cases.txt", cases);
        n_cases = 0;
        while (n_cases < MAX_CASES && !$isunknown(cases[n_cases])) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            errors++;
            $display("no cases were read from verification/cp_cases.txt");
        end
        add_random_cases();
        for (int i = 0; i < n_cases; i++) begin
            rom[12'h100 + i] = cases[i][39:28];
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        #1 rst_n = 1'b1;

        k = 0;
        while (k < n_cases && !timed_out) begin
            clocks = 0;
            do begin
                @(negedge clk);
                clocks++;
            end while (instr_done !== 1'b1 && clocks < TIMEOUT);
            if (instr_done !== 1'b1) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: no instr_done within %0d cycles at instruction %0d", TIMEOUT, k);
            end else begin
                check_case(k);
                k++;
            end
        end

        $display("%0d instructions checked, %0d errors", k, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/cp_cases.txt
// word_mask_carry_zero_waddr_wdata in hex; mask bit 0 checks flags, bit 1 checks RAM writes
// waddr FFF means no RAM write is expected during the instruction
B3A_3_0_0_FFF_0
8C5_3_0_0_FFF_0
A40_3_0_1_FFF_0
A55_3_0_0_FFF_0
A5A_3_0_1_FFF_0
A5C_3_1_0_FFF_0
A61_3_1_0_FFF_0
A72_3_0_0_FFF_0
A75_3_0_1_FFF_0
E07_3_0_1_FFF_0
E1C_3_0_1_FFF_0
E29_3_0_1_03A_9
E33_3_0_1_0C5_3
DC7_3_0_1_FFF_0
DDF_3_1_0_FFF_0
DEA_3_1_0_FFF_0
DF1_3_0_0_FFF_0
F00_3_0_1_FFF_0
F01_3_1_0_FFF_0
F02_3_1_0_FFF_0
F03_3_0_0_FFF_0
F04_3_0_0_FFF_0
F05_3_0_1_FFF_0
F06_3_0_0_FFF_0
F07_3_0_0_FFF_0
F08_3_0_0_FFF_0
F09_3_1_0_FFF_0
F0A_3_0_1_FFF_0
F0B_3_0_0_FFF_0
F0C_3_1_0_FFF_0
F0D_3_1_0_FFF_0
F0E_3_1_0_FFF_0
F0F_3_0_1_FFF_0
ECC_3_0_1_0C5_7
ECE_3_0_1_0C5_9
FFB_3_0_1_FFF_0

// File: sim.f
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/compare_unit.sv
hdl/cycle_sequencer.sv
hdl/cpu4_core.sv
verification/tb_clock.sv
verification/cpu4_tb.sv

// File: Bender.yml
package:
  name: cpu4

export_include_dirs:
  - include

sources:
  - hdl/isa_pkg.sv
  - hdl/core_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/reg_file.sv
  - hdl/compare_unit.sv
  - hdl/cycle_sequencer.sv
  - hdl/cpu4_core.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/cpu4_tb.sv
